// File: tx_arbiter_top.f
hdl/rq_tuser_pkg.sv
hdl/tx_arb_pkg.sv
hdl/arb_control.sv
hdl/wr_rd_ratio.sv
hdl/beat_select.sv
hdl/rq_out_reg.sv
hdl/pkt_stats.sv
hdl/tx_arbiter_top.sv
sim/tb_clock_gen.sv
sim/tx_arbiter_tb.sv

// File: sim/tx_arbiter_tb.sv
// Self-checking testbench for the request arbiter, run from the file list with top tx_arbiter_tb
`timescale 1ns/1ns

module tx_arbiter_tb;

  localparam int RR_START   = 5;
  localparam int NS         = tx_arb_pkg::NUM_SRC;
  localparam int DEPTH      = 80;                          // Beats stored per source
  localparam int TOTAL_PKTS = 24 + 12 + 18 + 6;
  localparam int WATCHDOG   = TOTAL_PKTS * 4 * 20 + 16;    // Cycles, all packets at 4 beats

  logic                                 user_clk;
  logic                                 reset_n;
  tx_arb_pkg::src_beat_t [NS-1:0]       i_src;
  tx_arb_pkg::src_mask_t                o_src_ready;
  tx_arb_pkg::rq_beat_t                 o_rq;
  logic                                 i_rq_ready;
  tx_arb_pkg::ratio_cfg_t               i_ratio;
  logic                                 i_stats_en;
  logic                                 i_stats_clr;
  tx_arb_pkg::stats_t                   o_stats;

  // ------------------------------
  // Stimulus store and model state
  // ------------------------------
  tx_arb_pkg::src_beat_t  beat_mem [NS][DEPTH];
  int                     wr_ptr [NS];
  int                     tx_ptr [NS];   // Next beat to present
  int                     rx_ptr [NS];   // Next beat expected at output
  int                     pend [NS];     // Packets not yet seen whole
  int                     pkt_no [NS];
  tx_arb_pkg::stats_t     exp_stats;
  tx_arb_pkg::ratio_cfg_t ref_cfg;
  logic                   ref_phase_rd;
  int                     ref_cnt;
  int                     last_src;
  int                     cur_src;
  logic                   in_pkt;
  logic                   count_en;
  logic                   bp_on;         // Random back-pressure
  int                     tx_total;
  int                     rx_total;
  logic                   hold_chk;
  tx_arb_pkg::rq_beat_t   prev_rq;
  tx_arb_pkg::rq_beat_t   exp_beat;
  int unsigned            seed;

  tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(16)) u_clock_gen (
    .o_user_clk (user_clk),
    .o_reset_n  (reset_n)
  );

  tx_arbiter_top #(.RR_START(RR_START)) DUT (
    .user_clk    (user_clk),
    .reset_n     (reset_n),
    .i_src       (i_src),
    .o_src_ready (o_src_ready),
    .o_rq        (o_rq),
    .i_rq_ready  (i_rq_ready),
    .i_ratio     (i_ratio),
    .i_stats_en  (i_stats_en),
    .i_stats_clr (i_stats_clr),
    .o_stats     (o_stats)
  );

  // ------------------------------
  // Reference functions
  // ------------------------------
  function automatic rq_tuser_pkg::rq_tuser_t expected_tuser(input int src, input logic [3:0] be);
    rq_tuser_pkg::rq_tuser_t t;
    t          = '0;
    t.seq_num0 = 6'd10;
    t.is_eop   = 2'b01;
    t.is_sop   = 2'b01;
    t.last_be  = 8'h0F;
    t.first_be = 8'h0F;
    if (src == tx_arb_pkg::SRC_RD_CWR || src == tx_arb_pkg::SRC_WR_CWR) begin
      t.last_be[3:0] = be;  // Completion writes bring their own
    end
    return t;
  endfunction

  // First source with work after the last winner, -1 when idle
  function automatic int expected_next(input int last, input tx_arb_pkg::src_mask_t avail,
                                       input logic wr_only, input logic rd_only);
    tx_arb_pkg::src_mask_t mask;
    int                    idx;
    mask = avail;
    if (wr_only) begin
      mask = avail & (tx_arb_pkg::src_mask_t'(1) << tx_arb_pkg::SRC_WR_DATA);
    end else if (rd_only) begin
      mask = avail & (tx_arb_pkg::src_mask_t'(1) << tx_arb_pkg::SRC_RD_DATA);
    end
    for (int off = 1; off <= NS; off++) begin
      idx = (last + off) % NS;
      if (mask[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  function automatic int predict_src();
    tx_arb_pkg::src_mask_t avail;
    logic                  wr_only;
    logic                  rd_only;
    for (int s = 0; s < NS; s++) begin
      avail[s] = (pend[s] > 0);
    end
    wr_only = !ref_phase_rd && (ref_cfg.wr_ratio != 0) && avail[tx_arb_pkg::SRC_WR_DATA];
    rd_only = ref_phase_rd && (ref_cfg.rd_ratio != 0) && avail[tx_arb_pkg::SRC_RD_DATA];
    return expected_next(last_src, avail, wr_only, rd_only);
  endfunction

  // Phase and count after one finished packet
  task automatic update_ratio_model(input int s);
    if (!ref_phase_rd) begin
      if (ref_cfg.wr_ratio == 0) begin
        ref_phase_rd = (ref_cfg.rd_ratio != 0);
        ref_cnt      = 0;
      end else if (s == tx_arb_pkg::SRC_WR_DATA) begin
        ref_cnt = ref_cnt + 1;
        if (ref_cnt >= ref_cfg.wr_ratio) begin
          ref_cnt      = 0;
          ref_phase_rd = (ref_cfg.rd_ratio != 0);
        end
      end
    end else begin
      if (ref_cfg.rd_ratio == 0) begin
        ref_phase_rd = (ref_cfg.wr_ratio == 0);
        ref_cnt      = 0;
      end else if (s == tx_arb_pkg::SRC_RD_DATA) begin
        ref_cnt = ref_cnt + 1;
        if (ref_cnt >= ref_cfg.rd_ratio) begin
          ref_cnt      = 0;
          ref_phase_rd = (ref_cfg.wr_ratio == 0);
        end
      end
    end
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, got));
    end
  endtask

  task automatic check_mask(input string name, input tx_arb_pkg::src_mask_t got,
                            input tx_arb_pkg::src_mask_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, got));
    end
  endtask

  task automatic check_beat(input string name, input tx_arb_pkg::rq_beat_t got,
                            input tx_arb_pkg::rq_beat_t exp);
    check_flag({name, ".valid"}, got.valid, exp.valid);
    check_flag({name, ".last"}, got.last, exp.last);
    if (got.keep !== exp.keep) begin
      fail_run($sformatf("error at %0t: %s.keep expected %h got %h",
                         $time, name, exp.keep, got.keep));
    end
    if (got.data !== exp.data) begin
      fail_run($sformatf("error at %0t: %s.data expected %h got %h",
                         $time, name, exp.data, got.data));
    end
  endtask

  task automatic check_tuser(input string name, input rq_tuser_pkg::rq_tuser_t got,
                             input rq_tuser_pkg::rq_tuser_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  task automatic check_stats(input tx_arb_pkg::stats_t got, input tx_arb_pkg::stats_t exp);
    for (int s = 0; s < NS; s++) begin
      if (got[s] !== exp[s]) begin
        fail_run($sformatf("error at %0t: o_stats[%0d] expected %0d got %0d",
                           $time, s, exp[s], got[s]));
      end
    end
  endtask

  task automatic check_reset_state();
    check_flag("o_rq.valid", o_rq.valid, 1'b0);
    check_mask("o_src_ready", o_src_ready, '0);
    check_stats(o_stats, '0);
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  // Called between edges, one packet of 1 to 4 tagged beats
  task automatic queue_packet(input int s);
    tx_arb_pkg::src_beat_t bt;
    int                    len;
    logic [31:0]           rnd;
    len = 1 + ($urandom % 4);
    for (int b = 0; b < len; b++) begin
      for (int w = 0; w < tx_arb_pkg::DATA_W / 32; w++) begin
        bt.data[w*32 +: 32] = $urandom;
      end
      bt.data[31:0] = {8'(s), 8'(pkt_no[s]), 8'(b), 8'hA5};  // Source, packet, beat
      rnd           = $urandom;
      bt.valid      = 1'b1;
      bt.keep       = rnd[tx_arb_pkg::KEEP_W-1:0];
      bt.last_be    = rnd[31:28];
      bt.last       = (b == len - 1);
      beat_mem[s][wr_ptr[s]] = bt;
      wr_ptr[s] = wr_ptr[s] + 1;
      tx_total  = tx_total + 1;
    end
    pkt_no[s] = pkt_no[s] + 1;
    pend[s]   = pend[s] + 1;
  endtask

  task automatic wait_drain();
    do begin
      @(negedge user_clk);
    end while (rx_total < tx_total);
    repeat (2) @(negedge user_clk);
  endtask

  // Sources present the next beat once the current one moves
  always @(posedge user_clk) begin
    if (reset_n) begin
      for (int s = 0; s < NS; s++) begin
        if (!i_src[s].valid || o_src_ready[s]) begin
          if (tx_ptr[s] < wr_ptr[s]) begin
            i_src[s] <= beat_mem[s][tx_ptr[s]];
            tx_ptr[s] = tx_ptr[s] + 1;
          end else begin
            i_src[s].valid <= 1'b0;
          end
        end
      end
    end
  end

  always @(posedge user_clk) begin
    i_rq_ready <= bp_on ? (($urandom % 3) != 0) : 1'b1;
  end

  // ------------------------------
  // Compare process
  // ------------------------------
  always @(posedge user_clk) begin
    if (reset_n) begin
      if (hold_chk) begin  // Stalled beat must not move
        check_beat("o_rq (stalled)", o_rq, prev_rq);
        check_tuser("o_rq.tuser (stalled)", o_rq.tuser, prev_rq.tuser);
      end
      if (o_rq.valid && !i_rq_ready) begin  // No source moves while output is stuck
        check_mask("o_src_ready (stalled)", o_src_ready, '0);
      end
      if (o_rq.valid && i_rq_ready) begin
        if (!in_pkt) begin
          cur_src = predict_src();
          if (cur_src < 0) begin
            fail_run("an output beat arrived while no source had a packet pending");
          end
          in_pkt = 1'b1;
        end
        exp_beat.valid = 1'b1;
        exp_beat.data  = beat_mem[cur_src][rx_ptr[cur_src]].data;
        exp_beat.keep  = beat_mem[cur_src][rx_ptr[cur_src]].keep;
        exp_beat.last  = beat_mem[cur_src][rx_ptr[cur_src]].last;
        exp_beat.tuser = expected_tuser(cur_src, beat_mem[cur_src][rx_ptr[cur_src]].last_be);
        check_beat("o_rq", o_rq, exp_beat);
        check_tuser("o_rq.tuser", o_rq.tuser, exp_beat.tuser);
        rx_ptr[cur_src] = rx_ptr[cur_src] + 1;
        rx_total        = rx_total + 1;
        if (exp_beat.last) begin
          in_pkt        = 1'b0;
          pend[cur_src] = pend[cur_src] - 1;
          update_ratio_model(cur_src);
          last_src = cur_src;
          if (count_en) begin
            exp_stats[cur_src] = exp_stats[cur_src] + 1;
          end
        end
      end
      hold_chk = o_rq.valid && !i_rq_ready;
      prev_rq  = o_rq;
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge user_clk);
    fail_run("watchdog expired before all packets came out of the arbiter");
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    seed = 32'h8175e53d;
    void'($urandom(seed));
    i_src       = '0;
    i_rq_ready  = 1'b0;
    i_ratio     = '0;
    i_stats_en  = 1'b0;
    i_stats_clr = 1'b0;
    for (int s = 0; s < NS; s++) begin
      wr_ptr[s] = 0;
      tx_ptr[s] = 0;
      rx_ptr[s] = 0;
      pend[s]   = 0;
      pkt_no[s] = 0;
    end
    exp_stats    = '0;
    ref_cfg      = '0;
    ref_phase_rd = 1'b0;
    ref_cnt      = 0;
    last_src     = RR_START;
    cur_src      = 0;
    in_pkt       = 1'b0;
    count_en     = 1'b0;
    bp_on        = 1'b0;
    tx_total     = 0;
    rx_total     = 0;
    hold_chk     = 1'b0;

    repeat (8) @(negedge user_clk);  // Inside reset
    check_reset_state();
    wait (reset_n);
    repeat (3) @(negedge user_clk);
    check_reset_state();

    @(posedge user_clk);
    i_stats_en <= 1'b1;
    @(negedge user_clk);
    count_en = 1'b1;
    for (int p = 0; p < 4; p++) begin  // Round robin, all six busy
      for (int s = 0; s < NS; s++) begin
        queue_packet(s);
      end
    end
    wait_drain();

    @(posedge user_clk);
    i_ratio.wr_ratio <= 16'd2;
    i_ratio.rd_ratio <= 16'd1;
    @(negedge user_clk);
    ref_cfg.wr_ratio = 16'd2;
    ref_cfg.rd_ratio = 16'd1;
    for (int p = 0; p < 4; p++) begin  // Two writes per read
      queue_packet(tx_arb_pkg::SRC_WR_DATA);
      queue_packet(tx_arb_pkg::SRC_WR_DATA);
      queue_packet(tx_arb_pkg::SRC_RD_DATA);
    end
    wait_drain();
    @(posedge user_clk);
    i_ratio <= '0;
    @(negedge user_clk);
    ref_cfg = '0;

    bp_on = 1'b1;
    for (int p = 0; p < 3; p++) begin
      for (int s = 0; s < NS; s++) begin
        queue_packet(s);
      end
    end
    wait_drain();
    bp_on = 1'b0;
    repeat (2) @(negedge user_clk);
    check_stats(o_stats, exp_stats);

    @(posedge user_clk);
    i_stats_en <= 1'b0;
    @(negedge user_clk);
    count_en = 1'b0;
    for (int s = 0; s < NS; s++) begin
      queue_packet(s);
    end
    wait_drain();
    check_stats(o_stats, exp_stats);

    @(posedge user_clk);
    i_stats_clr <= 1'b1;
    @(posedge user_clk);
    i_stats_clr <= 1'b0;
    @(negedge user_clk);
    exp_stats = '0;
    check_stats(o_stats, exp_stats);

    if (rx_total == tx_total && !in_pkt) begin
      $display("TEST OK");
      $finish;
    end else begin
      fail_run("beats were still missing at the end of the run");
    end
  end

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and power-on reset source, instantiated once by the arbiter testbench
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 10,  // ns
  parameter int RESET_CYCLES = 16
) (
  output logic o_user_clk,
  output logic o_reset_n
);

  initial begin
    o_user_clk = 1'b0;
    forever #(PERIOD / 2) o_user_clk = ~o_user_clk;
  end

  // Release on a rising edge after the hold time
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_user_clk);
    o_reset_n <= 1'b1;
  end

endmodule

// File: hdl/tx_arbiter_top.sv
// Top level of the six-source request arbiter, connecting grant, ratio, select, output and stats
`timescale 1ns/1ns

module tx_arbiter_top #(
  parameter int RR_START = 5
) (
  input  logic                                            user_clk,
  input  logic                                            reset_n,
  input  tx_arb_pkg::src_beat_t [tx_arb_pkg::NUM_SRC-1:0] i_src,
  output tx_arb_pkg::src_mask_t                           o_src_ready,
  output tx_arb_pkg::rq_beat_t                            o_rq,
  input  logic                                            i_rq_ready,
  input  tx_arb_pkg::ratio_cfg_t                          i_ratio,
  input  logic                                            i_stats_en,
  input  logic                                            i_stats_clr,
  output tx_arb_pkg::stats_t                              o_stats
);

  tx_arb_pkg::src_mask_t src_valid;
  tx_arb_pkg::src_mask_t grant;
  tx_arb_pkg::prio_t     prio;
  tx_arb_pkg::rq_beat_t  sel_beat;
  logic                  can_load;
  logic                  fire_last;

  for (genvar s = 0; s < tx_arb_pkg::NUM_SRC; s++) begin : g_valid
    assign src_valid[s] = i_src[s].valid;
  end

  // ------------------------------
  // Arbitration
  // ------------------------------
  arb_control #(
    .RR_START (RR_START)
  ) u_arb_control (
    .user_clk    (user_clk),
    .reset_n     (reset_n),
    .i_src_valid (src_valid),
    .i_can_load  (can_load),
    .i_prio      (prio),
    .i_fire_last (fire_last),
    .o_grant     (grant)
  );

  wr_rd_ratio u_wr_rd_ratio (
    .user_clk    (user_clk),
    .reset_n     (reset_n),
    .i_cfg       (i_ratio),
    .i_src_valid (src_valid),
    .i_grant     (grant),
    .i_fire_last (fire_last),
    .o_prio      (prio)
  );

  // ------------------------------
  // Datapath
  // ------------------------------
  beat_select u_beat_select (
    .i_src       (i_src),
    .i_grant     (grant),
    .i_can_load  (can_load),
    .o_src_ready (o_src_ready),
    .o_sel_beat  (sel_beat),
    .o_fire_last (fire_last)
  );

  rq_out_reg u_rq_out_reg (
    .user_clk   (user_clk),
    .reset_n    (reset_n),
    .i_beat     (sel_beat),
    .i_rq_ready (i_rq_ready),
    .o_can_load (can_load),
    .o_rq       (o_rq)
  );

  pkt_stats u_pkt_stats (
    .user_clk    (user_clk),
    .reset_n     (reset_n),
    .i_grant     (grant),
    .i_fire_last (fire_last),
    .i_en        (i_stats_en),
    .i_clr       (i_stats_clr),
    .o_stats     (o_stats)
  );

endmodule

// File: hdl/pkt_stats.sv
// Per-source completed packet counters with enable and clear for performance monitoring
`timescale 1ns/1ns

module pkt_stats (
  input  logic                  user_clk,
  input  logic                  reset_n,
  input  tx_arb_pkg::src_mask_t i_grant,
  input  logic                  i_fire_last,
  input  logic                  i_en,
  input  logic                  i_clr,
  output tx_arb_pkg::stats_t    o_stats
);

  tx_arb_pkg::stats_t cnt_q;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      cnt_q <= '0;
    end else if (i_clr) begin  // Clear wins over counting
      cnt_q <= '0;
    end else if (i_en && i_fire_last) begin
      for (int s = 0; s < tx_arb_pkg::NUM_SRC; s++) begin
        if (i_grant[s]) begin
          cnt_q[s] <= cnt_q[s] + tx_arb_pkg::CNT_W'(1);
        end
      end
    end
  end

  assign o_stats = cnt_q;

endmodule

// File: hdl/rq_out_reg.sv
// Registered request output stage that loads when empty or accepted and holds when stalled
`timescale 1ns/1ns

module rq_out_reg (
  input  logic                 user_clk,
  input  logic                 reset_n,
  input  tx_arb_pkg::rq_beat_t i_beat,
  input  logic                 i_rq_ready,
  output logic                 o_can_load,
  output tx_arb_pkg::rq_beat_t o_rq
);

  tx_arb_pkg::rq_beat_t beat_q;   // Payload
  logic                 valid_q;

  assign o_can_load = ~valid_q | i_rq_ready;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= 1'b0;
    end else if (o_can_load) begin
      valid_q <= i_beat.valid;  // Empty beat drains the stage
    end
  end

  always_ff @(posedge user_clk) begin
    if (o_can_load) begin
      beat_q <= i_beat;
    end
  end

  always_comb begin
    o_rq       = beat_q;
    o_rq.valid = valid_q;
  end

endmodule

// File: hdl/beat_select.sv
// Granted-source beat multiplexer with sideband build and per-source ready gating
`timescale 1ns/1ns

module beat_select (
  input  tx_arb_pkg::src_beat_t [tx_arb_pkg::NUM_SRC-1:0] i_src,
  input  tx_arb_pkg::src_mask_t                           i_grant,
  input  logic                                            i_can_load,
  output tx_arb_pkg::src_mask_t                           o_src_ready,
  output tx_arb_pkg::rq_beat_t                            o_sel_beat,
  output logic                                            o_fire_last
);

  tx_arb_pkg::src_beat_t   sel_src;
  rq_tuser_pkg::rq_tuser_t sel_tuser;

  // ------------------------------
  // One-hot select
  // ------------------------------
  always_comb begin
    sel_src   = '0;
    sel_tuser = rq_tuser_pkg::TUSER_BASE;
    for (int s = 0; s < tx_arb_pkg::NUM_SRC; s++) begin
      if (i_grant[s]) begin
        sel_src = i_src[s];
        // Completion writes carry their own last BE
        if (s == tx_arb_pkg::SRC_RD_CWR || s == tx_arb_pkg::SRC_WR_CWR) begin
          sel_tuser.last_be[3:0] = i_src[s].last_be;
        end
      end
    end
  end

  // Beat moves only when the output stage can take it
  always_comb begin
    o_sel_beat.valid = sel_src.valid & i_can_load;
    o_sel_beat.data  = sel_src.data;
    o_sel_beat.keep  = sel_src.keep;
    o_sel_beat.last  = sel_src.last;
    o_sel_beat.tuser = sel_tuser;
  end

  assign o_fire_last = o_sel_beat.valid & sel_src.last;  // End of locked packet

  assign o_src_ready = i_grant & {tx_arb_pkg::NUM_SRC{i_can_load}};

endmodule

// File: hdl/wr_rd_ratio.sv
// Weighted write/read phase tracking that narrows arbitration to one data source at a time
`timescale 1ns/1ns

module wr_rd_ratio (
  input  logic                  user_clk,
  input  logic                  reset_n,
  input  tx_arb_pkg::ratio_cfg_t i_cfg,
  input  tx_arb_pkg::src_mask_t i_src_valid,
  input  tx_arb_pkg::src_mask_t i_grant,
  input  logic                  i_fire_last,
  output tx_arb_pkg::prio_t     o_prio
);

  logic        phase_rd;  // Low in write phase
  logic [15:0] pkt_cnt;
  logic        wr_en;
  logic        rd_en;
  logic        wr_done;
  logic        rd_done;

  assign wr_en   = |i_cfg.wr_ratio;
  assign rd_en   = |i_cfg.rd_ratio;
  assign wr_done = i_grant[tx_arb_pkg::SRC_WR_DATA] & i_fire_last;
  assign rd_done = i_grant[tx_arb_pkg::SRC_RD_DATA] & i_fire_last;

  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      phase_rd <= 1'b0;
      pkt_cnt  <= '0;
    end else if (!phase_rd) begin
      if (!wr_en) begin
        phase_rd <= rd_en;  // Hand over to read side for good
        pkt_cnt  <= '0;
      end else if (wr_done) begin
        if (pkt_cnt == i_cfg.wr_ratio - 16'd1) begin
          pkt_cnt  <= '0;
          phase_rd <= rd_en;
        end else begin
          pkt_cnt <= pkt_cnt + 16'd1;
        end
      end
    end else begin
      if (!rd_en) begin
        phase_rd <= ~wr_en;
        pkt_cnt  <= '0;
      end else if (rd_done) begin
        if (pkt_cnt == i_cfg.rd_ratio - 16'd1) begin
          pkt_cnt  <= '0;
          phase_rd <= ~wr_en;
        end else begin
          pkt_cnt <= pkt_cnt + 16'd1;
        end
      end
    end
  end

  // Strict priority only while the favoured source has work
  assign o_prio.wr_only = ~phase_rd & wr_en & i_src_valid[tx_arb_pkg::SRC_WR_DATA];
  assign o_prio.rd_only = phase_rd & rd_en & i_src_valid[tx_arb_pkg::SRC_RD_DATA];

endmodule

// File: hdl/arb_control.sv
// Packet-locked round-robin grant logic, instantiated once by the arbiter top level
`timescale 1ns/1ns

module arb_control #(
  parameter int RR_START = 5  // Source treated as last granted after reset
) (
  input  logic                  user_clk,
  input  logic                  reset_n,
  input  tx_arb_pkg::src_mask_t i_src_valid,
  input  logic                  i_can_load,
  input  tx_arb_pkg::prio_t     i_prio,
  input  logic                  i_fire_last,
  output tx_arb_pkg::src_mask_t o_grant
);

  localparam int IDX_W = $clog2(tx_arb_pkg::NUM_SRC);

  tx_arb_pkg::src_mask_t prio_mask;
  tx_arb_pkg::src_mask_t eligible;
  tx_arb_pkg::src_mask_t grant_q;
  logic [IDX_W-1:0]      last_idx;    // Pointer, last granted source
  logic [IDX_W-1:0]      cur_idx;     // Source holding the grant
  logic [IDX_W-1:0]      next_idx;
  logic                  next_found;

  // ------------------------------
  // Eligibility
  // ------------------------------
  always_comb begin
    prio_mask = '1;
    if (i_prio.wr_only) begin
      prio_mask = '0;
      prio_mask[tx_arb_pkg::SRC_WR_DATA] = 1'b1;
    end else if (i_prio.rd_only) begin
      prio_mask = '0;
      prio_mask[tx_arb_pkg::SRC_RD_DATA] = 1'b1;
    end
  end

  assign eligible = i_src_valid & prio_mask & {tx_arb_pkg::NUM_SRC{i_can_load}};

  // ------------------------------
  // Rotation search
  // ------------------------------
  // Start one past the last winner and wrap once
  always_comb begin
    int idx;
    next_idx   = last_idx;
    next_found = 1'b0;
    for (int off = 1; off <= tx_arb_pkg::NUM_SRC; off++) begin
      idx = int'(last_idx) + off;
      if (idx >= tx_arb_pkg::NUM_SRC) begin
        idx = idx - tx_arb_pkg::NUM_SRC;
      end
      if (!next_found && eligible[idx]) begin
        next_idx   = IDX_W'(idx);
        next_found = 1'b1;
      end
    end
  end

  // ------------------------------
  // Grant register
  // ------------------------------
  always_ff @(posedge user_clk or negedge reset_n) begin
    if (!reset_n) begin
      grant_q  <= '0;
      last_idx <= IDX_W'(RR_START);
      cur_idx  <= '0;
    end else if (grant_q == '0) begin
      if (next_found) begin  // Lock onto a new packet
        grant_q <= tx_arb_pkg::src_mask_t'(1) << next_idx;
        cur_idx <= next_idx;
      end
    end else if (i_fire_last) begin
      // Packet done, free the lock and move the pointer
      grant_q  <= '0;
      last_idx <= cur_idx;
    end
  end

  assign o_grant = grant_q;

endmodule

// File: hdl/tx_arb_pkg.sv
// Source indices, beat structs and configuration types used across the transmit arbiter
package tx_arb_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int NUM_SRC = 6;
  localparam int DATA_W  = 512;
  localparam int KEEP_W  = DATA_W / 32;  // One keep bit per DW
  localparam int CNT_W   = 32;           // Packet counter width

  // Source indices, also the rotation order
  localparam int SRC_RD_CRD  = 0;
  localparam int SRC_RD_CWR  = 1;
  localparam int SRC_RD_DATA = 2;
  localparam int SRC_WR_DATA = 3;
  localparam int SRC_WR_CWR  = 4;
  localparam int SRC_WR_CRD  = 5;

  // One bit per source
  typedef logic [NUM_SRC-1:0] src_mask_t;

  // ------------------------------
  // Beats
  // ------------------------------
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
    logic [3:0]        last_be;  // Meaningful on completion-write sources
  } src_beat_t;

  typedef struct packed {
    logic                    valid;
    logic [DATA_W-1:0]       data;
    logic [KEEP_W-1:0]       keep;
    logic                    last;
    rq_tuser_pkg::rq_tuser_t tuser;
  } rq_beat_t;

  // Write ratio in the low half, read ratio in the high half
  typedef struct packed {
    logic [15:0] rd_ratio;
    logic [15:0] wr_ratio;
  } ratio_cfg_t;

  typedef struct packed {
    logic wr_only;  // Only the data-write source may win
    logic rd_only;  // Only the data-read source may win
  } prio_t;

  typedef logic [NUM_SRC-1:0][CNT_W-1:0] stats_t;

endpackage

// File: hdl/rq_tuser_pkg.sv
// Requester request sideband layout and its fixed field values, shared by the arbiter blocks
package rq_tuser_pkg;

  // ------------------------------
  // Sideband field layout
  // ------------------------------
  typedef struct packed {
    logic [63:0] parity;
    logic [5:0]  seq_num1;
    logic [5:0]  seq_num0;
    logic [15:0] tph_st_tag;      // Steering tag
    logic [1:0]  tph_ind_tag_en;
    logic [3:0]  tph_type;
    logic [1:0]  tph_present;
    logic        discontinue;
    logic [3:0]  eop1_ptr;        // Last DW offset, second TLP
    logic [3:0]  eop0_ptr;        // Last DW offset, first TLP
    logic [1:0]  is_eop;
    logic [1:0]  byte_lane32;
    logic [1:0]  byte_lane0;
    logic [1:0]  is_sop;
    logic [3:0]  addr_offset;     // Address aligned mode only
    logic [7:0]  last_be;
    logic [7:0]  first_be;
  } rq_tuser_t;

  localparam int TUSER_W = $bits(rq_tuser_t);

  // Fixed word for every request beat
  localparam rq_tuser_t TUSER_BASE = '{
    seq_num0: 6'd10,
    is_eop:   2'b01,
    is_sop:   2'b01,
    last_be:  8'h0F,
    first_be: 8'h0F,
    default:  '0
  };

endpackage
